// File: include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and pc width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// pc held by the decode register out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_INST_NOP 32'h0000_0013

`endif

// File: logic/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_imm    = 7'b0010011,
        opc_reg    = 7'b0110011
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
        alu_jalr,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
    } alu_op_t;

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_none} op1_sel_t;

    typedef enum logic [2:0] {op2_rs2, op2_imm_i, op2_imm_j, op2_imm_u, op2_none} op2_sel_t;

    // one row of the decode table
    typedef struct packed {
        alu_op_t  alu_op;
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
        logic     rf_wen;
        logic     uses_rs1;
        logic     uses_rs2;
        logic     jmp;
        logic     legal;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        alu_op_t             alu_op;
        logic [`RV_XLEN-1:0] op1;
        logic [`RV_XLEN-1:0] op2;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] br_off;   // imm_b
        logic [4:0]          rd;
        logic                rf_wen;
        logic                jmp;
        logic [4:0]          rs1_addr;
        logic [4:0]          rs2_addr;
    } dec_pkt_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
        logic                rf_wen;
    } wb_pkt_t;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  rv_pkg::wb_pkt_t     wr,
    input  logic                wr_en
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // old value on same-cycle write, hazard stall covers it
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    // top gates the write port on a nonzero rd
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst) wr_en |-> wr.rd != 5'd0);

endmodule

// File: logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

    a_stall_flush: assert property (@(posedge clk) disable iff (rst) !(stall && flush));

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::dec_pkt_t dec_pkt,
    input  logic             dec_valid,
    input  logic             wb_valid,
    input  logic [4:0]       wb_rd,
    input  logic             wb_wen,
    input  logic [4:0]       src_rs1,
    input  logic [4:0]       src_rs2,
    input  logic             src_uses_rs1,
    input  logic             src_uses_rs2,
    input  logic             redirect_valid,
    output logic             stall,
    output logic             flush
);

    logic ex_hit;
    logic wb_hit;

    function automatic logic reads(input logic [4:0] rd, input logic [4:0] a,
                                   input logic [4:0] b, input logic ua, input logic ub);
        return (rd != 5'd0) && ((ua && a == rd) || (ub && b == rd));
    endfunction

    always_comb begin
        ex_hit = dec_valid && dec_pkt.rf_wen
                 && reads(dec_pkt.rd, src_rs1, src_rs2, src_uses_rs1, src_uses_rs2);
        wb_hit = wb_valid && wb_wen
                 && reads(wb_rd, src_rs1, src_rs2, src_uses_rs1, src_uses_rs2);
    end

    assign flush = redirect_valid;
    assign stall = (ex_hit || wb_hit) && !redirect_valid;  // redirect wins

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  logic                in_valid,
    input  rv_pkg::fetch_pkt_t  in_pkt,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    output logic                uses_rs1,
    output logic                uses_rs2,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic                out_valid,
    output rv_pkg::dec_pkt_t    out_pkt
);

    logic                f_valid;
    rv_pkg::fetch_pkt_t  f_pkt;
    logic [31:0]         inst;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    rv_pkg::ctrl_t       ctrl;
    rv_pkg::dec_pkt_t    dec_next;

    function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    assign inst     = f_pkt.inst;
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        ctrl = '0;
        case (inst[6:0])
            rv_pkg::opc_reg: begin
                ctrl = '{arith_op(funct3, funct7[5]), rv_pkg::op1_rs1, rv_pkg::op2_rs2,
                         1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
                ctrl.legal = (funct7 == 7'h00)
                             || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_pkg::opc_imm: begin
                ctrl = '{arith_op(funct3, funct3 == 3'b101 && funct7[5]), rv_pkg::op1_rs1,
                         rv_pkg::op2_imm_i, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
                if (funct3 == 3'b001) ctrl.legal = (funct7 == 7'h00);
                if (funct3 == 3'b101) ctrl.legal = (funct7 == 7'h00 || funct7 == 7'h20);
            end
            rv_pkg::opc_branch: begin
                ctrl = '{rv_pkg::alu_beq, rv_pkg::op1_rs1, rv_pkg::op2_rs2,
                         1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
                case (funct3)
                    3'b000:  ctrl.alu_op = rv_pkg::alu_beq;
                    3'b001:  ctrl.alu_op = rv_pkg::alu_bne;
                    3'b100:  ctrl.alu_op = rv_pkg::alu_blt;
                    3'b101:  ctrl.alu_op = rv_pkg::alu_bge;
                    3'b110:  ctrl.alu_op = rv_pkg::alu_bltu;
                    3'b111:  ctrl.alu_op = rv_pkg::alu_bgeu;
                    default: ctrl.legal  = 1'b0;  // 010, 011 reserved
                endcase
            end
            rv_pkg::opc_jal:
                ctrl = '{rv_pkg::alu_add, rv_pkg::op1_pc, rv_pkg::op2_imm_j,
                         1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
            rv_pkg::opc_jalr:
                ctrl = '{rv_pkg::alu_jalr, rv_pkg::op1_rs1, rv_pkg::op2_imm_i,
                         1'b1, 1'b1, 1'b0, 1'b1, funct3 == 3'b000};
            rv_pkg::opc_lui:
                ctrl = '{rv_pkg::alu_add, rv_pkg::op1_none, rv_pkg::op2_imm_u,
                         1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
            rv_pkg::opc_auipc:
                ctrl = '{rv_pkg::alu_add, rv_pkg::op1_pc, rv_pkg::op2_imm_u,
                         1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
            default: ctrl = '0;  // bubble
        endcase
    end

    assign uses_rs1 = f_valid && ctrl.uses_rs1;
    assign uses_rs2 = f_valid && ctrl.uses_rs2;

    always_comb begin
        dec_next          = '0;
        dec_next.pc       = f_pkt.pc;
        dec_next.alu_op   = ctrl.alu_op;
        dec_next.rs2_data = rs2_data;
        dec_next.br_off   = imm_b;
        dec_next.rd       = inst[11:7];
        dec_next.rf_wen   = ctrl.rf_wen;
        dec_next.jmp      = ctrl.jmp;
        dec_next.rs1_addr = rs1_addr;
        dec_next.rs2_addr = rs2_addr;
        case (ctrl.op1_sel)
            rv_pkg::op1_rs1: dec_next.op1 = rs1_data;
            rv_pkg::op1_pc:  dec_next.op1 = f_pkt.pc;
            default:         dec_next.op1 = '0;
        endcase
        case (ctrl.op2_sel)
            rv_pkg::op2_rs2:   dec_next.op2 = rs2_data;
            rv_pkg::op2_imm_i: dec_next.op2 = imm_i;
            rv_pkg::op2_imm_j: dec_next.op2 = imm_j;
            rv_pkg::op2_imm_u: dec_next.op2 = imm_u;
            default:           dec_next.op2 = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            f_valid   <= 1'b0;
            f_pkt     <= '{pc: `RV_RESET_PC, inst: `RV_INST_NOP};
            out_valid <= 1'b0;
        end else begin
            if (flush) begin
                f_valid <= 1'b0;  // wrong path
            end else if (!stall) begin
                f_valid <= in_valid;
                f_pkt   <= in_pkt;
            end
            out_valid <= f_valid && ctrl.legal && !stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        out_pkt <= dec_next;
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module execute_stage (
    input  logic                dec_valid,
    input  rv_pkg::dec_pkt_t    dec_pkt,
    output logic                wb_valid,
    output rv_pkg::wb_pkt_t     wb_pkt,
    output logic                redirect_valid,
    output logic [`RV_XLEN-1:0] redirect_pc
);

    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] alu_out;
    logic [4:0]          shamt;
    logic                br_taken;

    assign a     = dec_pkt.op1;
    assign b     = dec_pkt.op2;
    assign sum   = a + b;
    assign shamt = b[4:0];

    always_comb begin
        case (dec_pkt.alu_op)
            rv_pkg::alu_sub:  alu_out = a - b;
            rv_pkg::alu_and:  alu_out = a & b;
            rv_pkg::alu_or:   alu_out = a | b;
            rv_pkg::alu_xor:  alu_out = a ^ b;
            rv_pkg::alu_sll:  alu_out = a << shamt;
            rv_pkg::alu_srl:  alu_out = a >> shamt;
            rv_pkg::alu_sra:  alu_out = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_slt:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu: alu_out = {{(`RV_XLEN-1){1'b0}}, a < b};
            default:          alu_out = sum;  // add, jalr target
        endcase
    end

    // branches compare rs1 against rs2 data
    always_comb begin
        case (dec_pkt.alu_op)
            rv_pkg::alu_beq:  br_taken = (a == dec_pkt.rs2_data);
            rv_pkg::alu_bne:  br_taken = (a != dec_pkt.rs2_data);
            rv_pkg::alu_blt:  br_taken = ($signed(a) < $signed(dec_pkt.rs2_data));
            rv_pkg::alu_bge:  br_taken = ($signed(a) >= $signed(dec_pkt.rs2_data));
            rv_pkg::alu_bltu: br_taken = (a < dec_pkt.rs2_data);
            rv_pkg::alu_bgeu: br_taken = (a >= dec_pkt.rs2_data);
            default:          br_taken = 1'b0;
        endcase
    end

    assign redirect_valid = dec_valid && (dec_pkt.jmp || br_taken);
    assign redirect_pc    = dec_pkt.jmp ? {sum[`RV_XLEN-1:1], 1'b0}
                                        : dec_pkt.pc + dec_pkt.br_off;

    assign wb_valid      = dec_valid && dec_pkt.rf_wen;  // branches commit nothing
    assign wb_pkt.pc     = dec_pkt.pc;
    assign wb_pkt.rd     = dec_pkt.rd;
    assign wb_pkt.rf_wen = dec_pkt.rf_wen;
    assign wb_pkt.data   = (dec_pkt.rd == 5'd0) ? '0
                         : dec_pkt.jmp ? dec_pkt.pc + `RV_XLEN'd4  // link value
                         : alu_out;

endmodule

// File: logic/rv_pipe_top.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_pipe_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  rv_pkg::fetch_pkt_t  in_pkt,
    output logic                in_ready,
    output logic                commit_valid,
    output rv_pkg::wb_pkt_t     commit,
    output logic                redirect_valid,
    output logic [`RV_XLEN-1:0] redirect_pc
);

    logic                stall;
    logic                flush;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic                uses_rs1;
    logic                uses_rs2;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                dec_valid;
    rv_pkg::dec_pkt_t    dec_pkt;
    logic                wb_valid;
    rv_pkg::wb_pkt_t     wb_pkt;
    logic                rf_wr_en;

    assign in_ready = !stall && !flush;
    assign rf_wr_en = commit_valid && commit.rf_wen && (commit.rd != 5'd0);

    decode_stage u_decode (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out_valid (dec_valid),
        .out_pkt   (dec_pkt)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (commit),
        .wr_en    (rf_wr_en)
    );

    hazard_unit u_hazard (
        .dec_pkt        (dec_pkt),
        .dec_valid      (dec_valid),
        .wb_valid       (commit_valid),
        .wb_rd          (commit.rd),
        .wb_wen         (commit.rf_wen),
        .src_rs1        (rs1_addr),
        .src_rs2        (rs2_addr),
        .src_uses_rs1   (uses_rs1),
        .src_uses_rs2   (uses_rs2),
        .redirect_valid (redirect_valid),
        .stall          (stall),
        .flush          (flush)
    );

    execute_stage u_execute (
        .dec_valid      (dec_valid),
        .dec_pkt        (dec_pkt),
        .wb_valid       (wb_valid),
        .wb_pkt         (wb_pkt),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // commit side has no back-pressure
    pipe_reg #(.payload_t(rv_pkg::wb_pkt_t)) u_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .stall     (1'b0),
        .flush     (1'b0),
        .in_valid  (wb_valid),
        .in_data   (wb_pkt),
        .out_valid (commit_valid),
        .out_data  (commit)
    );

endmodule

// File: bench/rv_pipe_tb.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_pipe_tb;

    logic                clk;
    logic                rst;
    logic                in_valid;
    rv_pkg::fetch_pkt_t  in_pkt;
    logic                in_ready;
    logic                commit_valid;
    rv_pkg::wb_pkt_t     commit;
    logic                redirect_valid;
    logic [`RV_XLEN-1:0] redirect_pc;
    logic                acc_valid;
    rv_pkg::fetch_pkt_t  acc_pkt;
    logic                track_v1;
    logic                track_v2;
    logic [31:0]         track_pc1;
    logic [31:0]         track_pc2;

    logic [31:0] i_pc[$];
    logic [31:0] i_inst[$];
    int          i_tgt[$];
    logic [31:0] c_pc[$];
    logic [31:0] c_data[$];
    int          c_rd[$];
    int          n_tgt = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          n_commit = 0;
    int          n_stall = 0;
    int          n_redirect = 0;

    rv_pipe_top dut (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_pkt         (in_pkt),
        .in_ready       (in_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // trace tap of accepted fetch packets
    pipe_reg #(.payload_t(rv_pkg::fetch_pkt_t)) u_trace (
        .clk       (clk),
        .rst       (rst),
        .stall     (1'b0),
        .flush     (1'b0),
        .in_valid  (in_valid && in_ready),
        .in_data   (in_pkt),
        .out_valid (acc_valid),
        .out_data  (acc_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // pcs listed in the C records are the ones that write a register
    function automatic bit expects_commit(input logic [31:0] pc);
        foreach (c_pc[k]) begin
            if (c_pc[k] == pc) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic load_stim;
        int          fd;
        int          r;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("bench/rv_pipe_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/rv_pipe_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r > 0 && line.getc(0) == "I") begin
                if ($sscanf(line, "I %h %h %d", a, b, n) == 3) begin
                    i_pc.push_back(a);
                    i_inst.push_back(b);
                    i_tgt.push_back(n);
                    if (n != 0) n_tgt++;
                end
            end else if (r > 0 && line.getc(0) == "C") begin
                if ($sscanf(line, "C %h %d %h", a, n, b) == 3) begin
                    c_pc.push_back(a);
                    c_rd.push_back(n);
                    c_data.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    // commit checker and stall counter
    always @(negedge clk) begin
        if (rst) begin
            check("commit_valid in reset", commit_valid, 0);
            check("redirect_valid in reset", redirect_valid, 0);
            track_v1 = 1'b0;
            track_v2 = 1'b0;
        end else begin
            if (!in_ready && !redirect_valid) n_stall++;
            if (track_v2) begin
                check("latency commit_valid", commit_valid, expects_commit(track_pc2));
                if (commit_valid) begin
                    check("latency commit pc", commit.pc, track_pc2);
                end
            end
            track_v2  = track_v1;
            track_pc2 = track_pc1;
            track_v1  = acc_valid && in_ready;  // decoded with no stall or flush
            track_pc1 = acc_pkt.pc;
            if (commit_valid) begin
                if (commit.rd == 5'd0) check("x0 commit data", commit.data, 0);
                if (n_commit < c_pc.size()) begin
                    check("commit pc", commit.pc, c_pc[n_commit]);
                    check("commit rd", commit.rd, c_rd[n_commit]);
                    check("commit data", commit.data, c_data[n_commit]);
                end else begin
                    $display("unexpected extra commit from pc %h", commit.pc);
                    errors++;
                end
                n_commit++;
            end
        end
    end

    initial begin
        int   idx;
        int   j;
        int   wait_cnt;
        logic held;
        in_valid = 1'b0;
        in_pkt   = '0;
        rst      = 1'b1;
        void'($urandom(32'hb2cc));
        load_stim();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("in_ready after reset", in_ready, 1);
        idx      = 0;
        held     = 1'b0;
        wait_cnt = 0;
        while (idx < i_pc.size() && wait_cnt < 200) begin
            if (redirect_valid) begin
                in_valid = 1'b0;  // fetch follows redirect_pc
                held     = 1'b0;
                n_redirect++;
                wait_cnt++;
                check("in_ready during redirect", in_ready, 0);
                j = idx;
                while (j < i_pc.size() && i_tgt[j] == 0) j++;
                if (j < i_pc.size()) begin
                    check("redirect_pc", redirect_pc, i_pc[j]);
                end else begin
                    $display("redirect to %h matches no branch target record", redirect_pc);
                    errors++;
                end
                idx = j;
            end else begin
                if (!held && ($urandom % 4 == 0)) begin
                    in_valid = 1'b0;  // idle cycle
                end else begin
                    in_valid = 1'b1;
                    in_pkt   = '{pc: i_pc[idx], inst: i_inst[idx]};
                end
                held = in_valid && !in_ready;
                if (in_valid && in_ready) begin
                    idx++;
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        if (wait_cnt >= 200) begin
            $display("fetch timed out, instruction %0d was never accepted", idx);
            timeouts++;
        end
        wait_cnt = 0;
        while (n_commit < c_pc.size() && wait_cnt < 100) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (n_commit < c_pc.size()) begin
            $display("timed out with %0d of %0d commits seen", n_commit, c_pc.size());
            timeouts++;
        end
        repeat (5) @(negedge clk);  // drain, catches extra commits
        check("commit count", n_commit, c_pc.size());
        check("redirect count", n_redirect, n_tgt);
        if (n_stall == 0) begin
            $display("in_ready never dropped for a hazard stall");
            errors++;
        end
        $display("errors %0d, timeouts %0d, commits %0d, redirects %0d, stalls %0d",
                 errors, timeouts, n_commit, n_redirect, n_stall);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/rv_pipe_stim.txt
# I pc inst target_flag : instruction fed by the fetch model, flag 1 marks a branch target
# C pc rd data          : expected commit in program order
I 00000000 00500093 0
I 00000004 ffd00113 0
I 00000008 002081b3 0
I 0000000c 40208233 0
I 00000010 00309293 0
I 00000014 40115313 0
I 00000018 00415393 0
I 0000001c 00112433 0
I 00000020 001134b3 0
I 00000024 fff0c513 0
I 00000028 00708013 0
I 0000002c 000005b3 0
I 00000030 12345637 0
I 00000034 00001697 0
I 00000038 00108663 0
I 0000003c 00100713 0
I 00000040 00200713 0
I 00000044 00109463 1
I 00000048 00114463 0
I 0000004c 00300713 0
I 00000050 00116463 1
I 00000054 0020d463 0
I 00000058 00400713 0
I 0000005c 00c007ef 1
I 00000060 00500713 0
I 00000064 00600713 0
I 00000068 08000813 1
I 0000006c 00c808e7 0
I 00000070 00700713 0
I 0000008c 0020f463 1
I 00000090 0020e933 0
I 00000094 0020f9b3 0
I 00000098 00109a33 0
I 0000009c 40115ab3 0
C 00000000 1 00000005
C 00000004 2 fffffffd
C 00000008 3 00000002
C 0000000c 4 00000008
C 00000010 5 00000028
C 00000014 6 fffffffe
C 00000018 7 0fffffff
C 0000001c 8 00000001
C 00000020 9 00000000
C 00000024 10 fffffffa
C 00000028 0 00000000
C 0000002c 11 00000000
C 00000030 12 12345000
C 00000034 13 00001034
C 0000005c 15 00000060
C 00000068 16 00000080
C 0000006c 17 00000070
C 00000090 18 fffffffd
C 00000094 19 00000005
C 00000098 20 000000a0
C 0000009c 21 ffffffff

// File: rv_pipe.f
+incdir+include
logic/rv_pkg.sv
logic/reg_file.sv
logic/pipe_reg.sv
logic/hazard_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv_pipe_top.sv
bench/rv_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_pipe_tb
RTL_TOP   ?= rv_pipe_top
FILELIST  ?= rv_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
